// File: hw/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int INSTR_WIDTH    = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int GPR_NUM        = 32;
    localparam int GPR_ADDR_WIDTH = $clog2(GPR_NUM);
    localparam int ALU_OP_WIDTH   = 8;
    localparam int ALU_SEL_WIDTH  = 3;

    // fetch queue depth, also the producer's starting credits
    localparam int FETCH_Q_DEPTH = 4;

    localparam logic [DATA_WIDTH-1:0] RESET_PC = 32'h1c000000;

    // major opcodes, instr[31:26]
    localparam logic [5:0] OPC_JIRL = 6'b010011;
    localparam logic [5:0] OPC_B    = 6'b010100;
    localparam logic [5:0] OPC_BL   = 6'b010101;
    localparam logic [5:0] OPC_BEQ  = 6'b010110;
    localparam logic [5:0] OPC_BNE  = 6'b010111;
    localparam logic [5:0] OPC_BLT  = 6'b011000;
    localparam logic [5:0] OPC_BGE  = 6'b011001;
    localparam logic [5:0] OPC_BLTU = 6'b011010;
    localparam logic [5:0] OPC_BGEU = 6'b011011;

    // alu op codes, zero is none
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_B    = 8'h01;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BL   = 8'h02;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_JIRL = 8'h03;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BEQ  = 8'h04;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BNE  = 8'h05;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BLT  = 8'h06;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BGE  = 8'h07;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BLTU = 8'h08;
    localparam logic [ALU_OP_WIDTH-1:0] ALUOP_BGEU = 8'h09;

    // result selector codes
    localparam logic [ALU_SEL_WIDTH-1:0] ALUSEL_JUMP   = 3'd1;
    localparam logic [ALU_SEL_WIDTH-1:0] ALUSEL_BRANCH = 3'd2;

    typedef enum logic [2:0] {
        BRANCH_NONE     = 3'd0,
        BRANCH_UNCOND   = 3'd1,
        BRANCH_CALL     = 3'd2,
        BRANCH_COND     = 3'd3,
        BRANCH_RETURN   = 3'd4,
        BRANCH_INDIRECT = 3'd5
    } branch_type_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  pc;
        logic [INSTR_WIDTH-1:0] instr;
    } fetch_entry_t;

endpackage

// File: hw/decoder_i26.sv
`timescale 1ns/1ps

// B and BL, layout {opcode[6], offs[15:0], offs[25:16]}
module decoder_i26
    import core_pkg::*;
(
    input  logic [INSTR_WIDTH-1:0]    instr_i,
    output logic                      decode_result_valid_o,
    output logic [DATA_WIDTH-1:0]     imm_o,
    output logic                      reg_write_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] reg_write_addr_o,
    output logic [ALU_OP_WIDTH-1:0]   aluop_o,
    output logic [ALU_SEL_WIDTH-1:0]  alusel_o,
    output branch_type_t              branch_type_o
);

    logic [25:0] offs_26;

    // high part sits in the low instruction bits
    assign offs_26 = {instr_i[9:0], instr_i[25:10]};

    always_comb begin
        decode_result_valid_o = 1'b1;
        imm_o                 = {{4{offs_26[25]}}, offs_26, 2'b00};
        reg_write_valid_o     = 1'b0;
        reg_write_addr_o      = '0;
        alusel_o              = ALUSEL_JUMP;
        case (instr_i[31:26])
            OPC_B: begin
                aluop_o       = ALUOP_B;
                branch_type_o = BRANCH_UNCOND;
            end
            OPC_BL: begin
                aluop_o           = ALUOP_BL;
                branch_type_o     = BRANCH_CALL;
                // link register is r1
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = GPR_ADDR_WIDTH'(1);
            end
            default: begin
                decode_result_valid_o = 1'b0;
                imm_o                 = '0;
                aluop_o               = '0;
                alusel_o              = '0;
                branch_type_o         = BRANCH_NONE;
            end
        endcase
    end

endmodule

// File: hw/decoder_i16.sv
`timescale 1ns/1ps

// JIRL and conditional branches, layout {opcode[6], offs[15:0], rj[5], rd[5]}
module decoder_i16
    import core_pkg::*;
(
    input  logic [INSTR_WIDTH-1:0]    instr_i,
    output logic                      decode_result_valid_o,
    output logic [DATA_WIDTH-1:0]     imm_o,
    output logic [1:0]                reg_read_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] reg_read_addr0_o,
    output logic [GPR_ADDR_WIDTH-1:0] reg_read_addr1_o,
    output logic                      reg_write_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] reg_write_addr_o,
    output logic [ALU_OP_WIDTH-1:0]   aluop_o,
    output logic [ALU_SEL_WIDTH-1:0]  alusel_o,
    output branch_type_t              branch_type_o
);

    logic [GPR_ADDR_WIDTH-1:0] rj;
    logic [GPR_ADDR_WIDTH-1:0] rd;

    assign rj = instr_i[9:5];
    assign rd = instr_i[4:0];

    always_comb begin
        // defaults describe a conditional branch
        decode_result_valid_o = 1'b1;
        imm_o                 = {{14{instr_i[25]}}, instr_i[25:10], 2'b00};
        reg_read_valid_o      = 2'b11;
        reg_read_addr0_o      = rj;
        reg_read_addr1_o      = rd;
        reg_write_valid_o     = 1'b0;
        reg_write_addr_o      = '0;
        alusel_o              = ALUSEL_BRANCH;
        branch_type_o         = BRANCH_COND;
        aluop_o               = '0;
        case (instr_i[31:26])
            OPC_BEQ:  aluop_o = ALUOP_BEQ;
            OPC_BNE:  aluop_o = ALUOP_BNE;
            OPC_BLT:  aluop_o = ALUOP_BLT;
            OPC_BGE:  aluop_o = ALUOP_BGE;
            OPC_BLTU: aluop_o = ALUOP_BLTU;
            OPC_BGEU: aluop_o = ALUOP_BGEU;
            OPC_JIRL: begin
                aluop_o           = ALUOP_JIRL;
                alusel_o          = ALUSEL_JUMP;
                // only rj is read, rd takes the link
                reg_read_valid_o  = 2'b01;
                reg_read_addr1_o  = '0;
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                // jirl r0, r1, 0 style is a return
                if (rd == '0 && rj == GPR_ADDR_WIDTH'(1)) begin
                    branch_type_o = BRANCH_RETURN;
                end else begin
                    branch_type_o = BRANCH_INDIRECT;
                end
            end
            default: begin
                decode_result_valid_o = 1'b0;
                imm_o                 = '0;
                reg_read_valid_o      = '0;
                reg_read_addr0_o      = '0;
                reg_read_addr1_o      = '0;
                alusel_o              = '0;
                branch_type_o         = BRANCH_NONE;
            end
        endcase
    end

endmodule

// File: hw/fetch_producer.sv
`timescale 1ns/1ps

module fetch_producer
    import core_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   in_valid_i,
    input  logic [INSTR_WIDTH-1:0] in_instr_i,
    output logic                   in_ready_o,
    output logic                   push_o,
    output fetch_entry_t           push_entry_o,
    input  logic                   credit_return_i
);

    localparam int CREDIT_WIDTH = $clog2(FETCH_Q_DEPTH + 1);

    logic [CREDIT_WIDTH-1:0] credits_q;
    logic [DATA_WIDTH-1:0]   pc_q;

    assign in_ready_o = (credits_q != '0);
    assign push_o     = in_valid_i && in_ready_o;

    assign push_entry_o.pc    = pc_q;
    assign push_entry_o.instr = in_instr_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits_q <= CREDIT_WIDTH'(FETCH_Q_DEPTH);
            pc_q      <= RESET_PC;
        end else begin
            // push and return in one cycle cancel out
            case ({push_o, credit_return_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
            if (push_o) begin
                pc_q <= pc_q + DATA_WIDTH'(4);
            end
        end
    end

endmodule

// File: hw/fetch_queue.sv
`timescale 1ns/1ps

// no full flag, the sender's credits bound the occupancy
module fetch_queue
    import core_pkg::*;
#(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     head_valid_o,
    output payload_t head_data_o,
    output logic     credit_return_o
);

    localparam int PTR_WIDTH   = $clog2(FETCH_Q_DEPTH);
    localparam int COUNT_WIDTH = $clog2(FETCH_Q_DEPTH + 1);

    payload_t               mem [FETCH_Q_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr_q;
    logic [PTR_WIDTH-1:0]   rd_ptr_q;
    logic [COUNT_WIDTH-1:0] count_q;

    assign head_valid_o = (count_q != '0);
    assign head_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q        <= '0;
            rd_ptr_q        <= '0;
            count_q         <= '0;
            credit_return_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(FETCH_Q_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(FETCH_Q_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // one credit back per freed slot
            credit_return_o <= pop_i;
        end
    end

endmodule

// File: hw/branch_decode_stage.sv
`timescale 1ns/1ps

module branch_decode_stage
    import core_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      head_valid_i,
    input  fetch_entry_t              head_entry_i,
    output logic                      pop_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [DATA_WIDTH-1:0]     out_pc_o,
    output logic [DATA_WIDTH-1:0]     out_imm_o,
    output logic [DATA_WIDTH-1:0]     out_target_o,
    output logic                      out_illegal_o,
    output logic                      out_reg_write_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] out_reg_write_addr_o,
    output logic [1:0]                out_reg_read_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] out_reg_read_addr0_o,
    output logic [GPR_ADDR_WIDTH-1:0] out_reg_read_addr1_o,
    output logic [ALU_OP_WIDTH-1:0]   out_aluop_o,
    output logic [ALU_SEL_WIDTH-1:0]  out_alusel_o,
    output branch_type_t              out_branch_type_o
);

    logic                      i26_valid;
    logic [DATA_WIDTH-1:0]     i26_imm;
    logic                      i26_wr_valid;
    logic [GPR_ADDR_WIDTH-1:0] i26_wr_addr;
    logic [ALU_OP_WIDTH-1:0]   i26_aluop;
    logic [ALU_SEL_WIDTH-1:0]  i26_alusel;
    branch_type_t              i26_btype;

    logic                      i16_valid;
    logic [DATA_WIDTH-1:0]     i16_imm;
    logic [1:0]                i16_rd_valid;
    logic [GPR_ADDR_WIDTH-1:0] i16_rd_addr0;
    logic [GPR_ADDR_WIDTH-1:0] i16_rd_addr1;
    logic                      i16_wr_valid;
    logic [GPR_ADDR_WIDTH-1:0] i16_wr_addr;
    logic [ALU_OP_WIDTH-1:0]   i16_aluop;
    logic [ALU_SEL_WIDTH-1:0]  i16_alusel;
    branch_type_t              i16_btype;

    logic                      legal;
    logic                      reg_based;
    logic [DATA_WIDTH-1:0]     imm;

    decoder_i26 u_dec_i26 (
        .instr_i               (head_entry_i.instr),
        .decode_result_valid_o (i26_valid),
        .imm_o                 (i26_imm),
        .reg_write_valid_o     (i26_wr_valid),
        .reg_write_addr_o      (i26_wr_addr),
        .aluop_o               (i26_aluop),
        .alusel_o              (i26_alusel),
        .branch_type_o         (i26_btype)
    );

    decoder_i16 u_dec_i16 (
        .instr_i               (head_entry_i.instr),
        .decode_result_valid_o (i16_valid),
        .imm_o                 (i16_imm),
        .reg_read_valid_o      (i16_rd_valid),
        .reg_read_addr0_o      (i16_rd_addr0),
        .reg_read_addr1_o      (i16_rd_addr1),
        .reg_write_valid_o     (i16_wr_valid),
        .reg_write_addr_o      (i16_wr_addr),
        .aluop_o               (i16_aluop),
        .alusel_o              (i16_alusel),
        .branch_type_o         (i16_btype)
    );

    // the two opcode sets are disjoint
    assign legal     = i26_valid || i16_valid;
    assign imm       = i26_valid ? i26_imm : i16_imm;
    // jirl target needs rj, unknown here
    assign reg_based = (i16_btype == BRANCH_RETURN) || (i16_btype == BRANCH_INDIRECT);

    // take a new entry when the register is free or draining
    assign pop_o = head_valid_i && (!out_valid_o || out_ready_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (pop_o) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            // pc is kept for illegal words too
            out_pc_o              <= head_entry_i.pc;
            out_imm_o             <= imm;
            out_target_o          <= (legal && !reg_based) ? head_entry_i.pc + imm : '0;
            out_illegal_o         <= !legal;
            out_reg_write_valid_o <= i26_valid ? i26_wr_valid : i16_wr_valid;
            out_reg_write_addr_o  <= i26_valid ? i26_wr_addr : i16_wr_addr;
            out_reg_read_valid_o  <= i16_rd_valid;
            out_reg_read_addr0_o  <= i16_rd_addr0;
            out_reg_read_addr1_o  <= i16_rd_addr1;
            out_aluop_o           <= i26_valid ? i26_aluop : i16_aluop;
            out_alusel_o          <= i26_valid ? i26_alusel : i16_alusel;
            out_branch_type_o     <= i26_valid ? i26_btype : i16_btype;
        end
    end

endmodule

// File: hw/branch_decode_top.sv
`timescale 1ns/1ps

module branch_decode_top
    import core_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      in_valid_i,
    input  logic [INSTR_WIDTH-1:0]    in_instr_i,
    output logic                      in_ready_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [DATA_WIDTH-1:0]     out_pc_o,
    output logic [DATA_WIDTH-1:0]     out_imm_o,
    output logic [DATA_WIDTH-1:0]     out_target_o,
    output logic                      out_illegal_o,
    output logic                      out_reg_write_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] out_reg_write_addr_o,
    output logic [1:0]                out_reg_read_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] out_reg_read_addr0_o,
    output logic [GPR_ADDR_WIDTH-1:0] out_reg_read_addr1_o,
    output logic [ALU_OP_WIDTH-1:0]   out_aluop_o,
    output logic [ALU_SEL_WIDTH-1:0]  out_alusel_o,
    output branch_type_t              out_branch_type_o
);

    logic         push;
    fetch_entry_t push_entry;
    logic         credit_return;
    logic         head_valid;
    fetch_entry_t head_entry;
    logic         pop;

    fetch_producer u_producer (
        .clk             (clk),
        .rst_i           (rst_i),
        .in_valid_i      (in_valid_i),
        .in_instr_i      (in_instr_i),
        .in_ready_o      (in_ready_o),
        .push_o          (push),
        .push_entry_o    (push_entry),
        .credit_return_i (credit_return)
    );

    fetch_queue #(
        .payload_t (fetch_entry_t)
    ) u_queue (
        .clk             (clk),
        .rst_i           (rst_i),
        .push_i          (push),
        .push_data_i     (push_entry),
        .pop_i           (pop),
        .head_valid_o    (head_valid),
        .head_data_o     (head_entry),
        .credit_return_o (credit_return)
    );

    branch_decode_stage u_stage (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .head_valid_i          (head_valid),
        .head_entry_i          (head_entry),
        .pop_o                 (pop),
        .out_valid_o           (out_valid_o),
        .out_ready_i           (out_ready_i),
        .out_pc_o              (out_pc_o),
        .out_imm_o             (out_imm_o),
        .out_target_o          (out_target_o),
        .out_illegal_o         (out_illegal_o),
        .out_reg_write_valid_o (out_reg_write_valid_o),
        .out_reg_write_addr_o  (out_reg_write_addr_o),
        .out_reg_read_valid_o  (out_reg_read_valid_o),
        .out_reg_read_addr0_o  (out_reg_read_addr0_o),
        .out_reg_read_addr1_o  (out_reg_read_addr1_o),
        .out_aluop_o           (out_aluop_o),
        .out_alusel_o          (out_alusel_o),
        .out_branch_type_o     (out_branch_type_o)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam realtime HALF_PERIOD  = 5ns;
    localparam int      RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset high from time zero
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: bench/branch_decode_chk.sv
`timescale 1ns/1ps

module branch_decode_chk
    import core_pkg::*;
#(
    parameter int FIELDS_WIDTH = 129
) (
    input logic                                 clk,
    input logic                                 rst_i,
    input logic                                 push_i,
    input logic [$clog2(FETCH_Q_DEPTH + 1)-1:0] queue_count_i,
    input logic [$clog2(FETCH_Q_DEPTH + 1)-1:0] credits_i,
    input logic                                 out_valid_i,
    input logic                                 out_ready_i,
    input logic [FIELDS_WIDTH-1:0]              fields_i
);

    int unsigned error_count = 0;

    // a stalled result must not change
    stall_stable: assert property (@(posedge clk) disable iff (rst_i)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(fields_i)))
    else begin
        error_count++;
        $error("output changed while stalled");
    end

    credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        credits_i <= FETCH_Q_DEPTH)
    else begin
        error_count++;
        $error("producer credits above queue depth");
    end

    // credits must keep every push inside the queue
    push_needs_room: assert property (@(posedge clk) disable iff (rst_i)
        push_i |-> (queue_count_i < FETCH_Q_DEPTH))
    else begin
        error_count++;
        $error("push into a full fetch queue");
    end

    reset_clears_valid: assert property (@(posedge clk) rst_i |=> !out_valid_i)
    else begin
        error_count++;
        $error("out_valid_o high after a reset cycle");
    end

endmodule

bind branch_decode_top branch_decode_chk u_chk (
    .clk           (clk),
    .rst_i         (rst_i),
    .push_i        (push),
    .queue_count_i (u_queue.count_q),
    .credits_i     (u_producer.credits_q),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .fields_i      ({out_pc_o, out_imm_o, out_target_o, out_illegal_o,
                     out_reg_write_valid_o, out_reg_write_addr_o, out_reg_read_valid_o,
                     out_reg_read_addr0_o, out_reg_read_addr1_o, out_aluop_o,
                     out_alusel_o, out_branch_type_o})
);

// File: bench/branch_decode_tb.sv
`timescale 1ns/1ps

module branch_decode_tb
    import core_pkg::*;
();

    localparam int MAX_ROWS          = 64;
    localparam int RANDOM_ROWS       = 35;
    // rows checked under random back-pressure, the rest with out_ready_i high
    localparam int BACKPRESSURE_ROWS = 40;
    localparam int TIMEOUT_CYCLES    = 200;
    localparam int READY_LOW_PCT     = 30;

    typedef struct packed {
        logic [INSTR_WIDTH-1:0]    instr;
        logic [DATA_WIDTH-1:0]     imm;
        logic [DATA_WIDTH-1:0]     target;
        logic                      illegal;
        logic                      wr_valid;
        logic [GPR_ADDR_WIDTH-1:0] wr_addr;
        logic [1:0]                rd_valid;
        logic [GPR_ADDR_WIDTH-1:0] rd_addr0;
        logic [GPR_ADDR_WIDTH-1:0] rd_addr1;
        logic [ALU_OP_WIDTH-1:0]   aluop;
        logic [ALU_SEL_WIDTH-1:0]  alusel;
        logic [2:0]                btype;
    } expect_t;

    logic                      clk;
    logic                      rst_i;
    logic                      in_valid_i;
    logic [INSTR_WIDTH-1:0]    in_instr_i;
    logic                      in_ready_o;
    logic                      out_valid_o;
    logic                      out_ready_i;
    logic [DATA_WIDTH-1:0]     out_pc_o;
    logic [DATA_WIDTH-1:0]     out_imm_o;
    logic [DATA_WIDTH-1:0]     out_target_o;
    logic                      out_illegal_o;
    logic                      out_reg_write_valid_o;
    logic [GPR_ADDR_WIDTH-1:0] out_reg_write_addr_o;
    logic [1:0]                out_reg_read_valid_o;
    logic [GPR_ADDR_WIDTH-1:0] out_reg_read_addr0_o;
    logic [GPR_ADDR_WIDTH-1:0] out_reg_read_addr1_o;
    logic [ALU_OP_WIDTH-1:0]   out_aluop_o;
    logic [ALU_SEL_WIDTH-1:0]  out_alusel_o;
    branch_type_t              out_branch_type_o;

    expect_t     rows [MAX_ROWS];
    int          n_rows;
    logic [31:0] lcg_state;
    logic        ready_fell;
    logic        ready_recovered;

    tb_clock_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst_i)
    );

    branch_decode_top DUT (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .in_valid_i            (in_valid_i),
        .in_instr_i            (in_instr_i),
        .in_ready_o            (in_ready_o),
        .out_valid_o           (out_valid_o),
        .out_ready_i           (out_ready_i),
        .out_pc_o              (out_pc_o),
        .out_imm_o             (out_imm_o),
        .out_target_o          (out_target_o),
        .out_illegal_o         (out_illegal_o),
        .out_reg_write_valid_o (out_reg_write_valid_o),
        .out_reg_write_addr_o  (out_reg_write_addr_o),
        .out_reg_read_valid_o  (out_reg_read_valid_o),
        .out_reg_read_addr0_o  (out_reg_read_addr0_o),
        .out_reg_read_addr1_o  (out_reg_read_addr1_o),
        .out_aluop_o           (out_aluop_o),
        .out_alusel_o          (out_alusel_o),
        .out_branch_type_o     (out_branch_type_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] word_i26(logic [5:0] opc, logic [25:0] offs);
        return {opc, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] word_i16(logic [5:0] opc, logic [15:0] offs,
                                             logic [4:0] rj, logic [4:0] rd);
        return {opc, offs, rj, rd};
    endfunction

    // reference model of the branch decode rules
    function automatic expect_t model_decode(logic [31:0] instr, logic [31:0] pc);
        expect_t            e;
        logic [5:0]         opc;
        logic [4:0]         rj;
        logic [4:0]         rd;
        logic signed [25:0] offs26;
        logic signed [15:0] offs16;
        e        = '0;
        e.instr  = instr;
        opc      = instr[31:26];
        rj       = instr[9:5];
        rd       = instr[4:0];
        offs26   = {instr[9:0], instr[25:10]};
        offs16   = instr[25:10];
        if (opc == OPC_B || opc == OPC_BL) begin
            e.imm    = int'(offs26) * 4;
            e.target = pc + e.imm;
            e.alusel = ALUSEL_JUMP;
            if (opc == OPC_B) begin
                e.aluop = ALUOP_B;
                e.btype = BRANCH_UNCOND;
            end else begin
                e.aluop    = ALUOP_BL;
                e.btype    = BRANCH_CALL;
                e.wr_valid = 1'b1;
                e.wr_addr  = 5'd1;
            end
        end else if (opc == OPC_JIRL) begin
            e.imm      = int'(offs16) * 4;
            e.rd_valid = 2'b01;
            e.rd_addr0 = rj;
            e.wr_valid = 1'b1;
            e.wr_addr  = rd;
            e.aluop    = ALUOP_JIRL;
            e.alusel   = ALUSEL_JUMP;
            e.btype    = (rd == 5'd0 && rj == 5'd1) ? BRANCH_RETURN : BRANCH_INDIRECT;
        end else if (opc >= OPC_BEQ && opc <= OPC_BGEU) begin
            e.imm      = int'(offs16) * 4;
            e.target   = pc + e.imm;
            e.rd_valid = 2'b11;
            e.rd_addr0 = rj;
            e.rd_addr1 = rd;
            e.alusel   = ALUSEL_BRANCH;
            e.btype    = BRANCH_COND;
            case (opc)
                OPC_BEQ:  e.aluop = ALUOP_BEQ;
                OPC_BNE:  e.aluop = ALUOP_BNE;
                OPC_BLT:  e.aluop = ALUOP_BLT;
                OPC_BGE:  e.aluop = ALUOP_BGE;
                OPC_BLTU: e.aluop = ALUOP_BLTU;
                default:  e.aluop = ALUOP_BGEU;
            endcase
        end else begin
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic add_row(logic [31:0] instr);
        rows[n_rows] = model_decode(instr, RESET_PC + 32'(4 * n_rows));
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] body;
        logic [5:0]  opc;
        add_row(word_i26(OPC_B, 26'h0000001));
        add_row(word_i26(OPC_B, 26'h3ffffff));
        add_row(word_i26(OPC_B, 26'h1ffffff));
        add_row(word_i26(OPC_B, 26'h2000000));
        add_row(word_i26(OPC_BL, 26'h0123456));
        add_row(word_i26(OPC_BL, 26'h3fff800));
        add_row(word_i16(OPC_BEQ, 16'h0010, 5'd3, 5'd4));
        add_row(word_i16(OPC_BNE, 16'hffff, 5'd31, 5'd0));
        add_row(word_i16(OPC_BLT, 16'h7fff, 5'd7, 5'd8));
        add_row(word_i16(OPC_BGE, 16'h8000, 5'd12, 5'd13));
        add_row(word_i16(OPC_BLTU, 16'h0001, 5'd1, 5'd2));
        add_row(word_i16(OPC_BGEU, 16'hfffe, 5'd30, 5'd29));
        // return only for rd 0 and rj 1
        add_row(word_i16(OPC_JIRL, 16'h0000, 5'd1, 5'd0));
        add_row(word_i16(OPC_JIRL, 16'h0004, 5'd1, 5'd1));
        add_row(word_i16(OPC_JIRL, 16'h0000, 5'd2, 5'd0));
        add_row(word_i16(OPC_JIRL, 16'hfff0, 5'd5, 5'd1));
        add_row(32'h0000_0000);
        add_row(32'hffff_ffff);
        add_row(word_i16(6'b010010, 16'h1234, 5'd1, 5'd0));
        add_row(word_i16(6'b011100, 16'h8001, 5'd4, 5'd5));
        add_row(word_i26(6'b110100, 26'h0000040));
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            r    = lcg_next();
            body = lcg_next();
            // mostly legal opcodes, which are contiguous from jirl
            if (r[31:30] != 2'b00) begin
                opc = OPC_JIRL + 6'((r >> 8) % 9);
            end else begin
                opc = r[29:24];
            end
            add_row({opc, body[25:0]});
        end
    endtask

    task automatic stop_on_error(string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else begin
            stop_on_error($sformatf("Mismatch at %0t: %s got 0x%08h expected 0x%08h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_result(int idx);
        expect_t e;
        e = rows[idx];
        check_field("out_pc_o", out_pc_o, RESET_PC + 32'(4 * idx));
        check_field("out_imm_o", out_imm_o, e.imm);
        check_field("out_target_o", out_target_o, e.target);
        check_field("out_illegal_o", 32'(out_illegal_o), 32'(e.illegal));
        check_field("out_reg_write_valid_o", 32'(out_reg_write_valid_o), 32'(e.wr_valid));
        check_field("out_reg_write_addr_o", 32'(out_reg_write_addr_o), 32'(e.wr_addr));
        check_field("out_reg_read_valid_o", 32'(out_reg_read_valid_o), 32'(e.rd_valid));
        check_field("out_reg_read_addr0_o", 32'(out_reg_read_addr0_o), 32'(e.rd_addr0));
        check_field("out_reg_read_addr1_o", 32'(out_reg_read_addr1_o), 32'(e.rd_addr1));
        check_field("out_aluop_o", 32'(out_aluop_o), 32'(e.aluop));
        check_field("out_alusel_o", 32'(out_alusel_o), 32'(e.alusel));
        check_field("out_branch_type_o", 32'(out_branch_type_o), 32'(e.btype));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (rst_i) begin
            cycles++;
            assert (cycles < TIMEOUT_CYCLES)
            else stop_on_error("reset was never released");
            @(posedge clk);
        end
    endtask

    task automatic drive_rows();
        int cycles;
        wait_reset_release();
        for (int i = 0; i < n_rows; i++) begin
            in_valid_i <= 1'b1;
            in_instr_i <= rows[i].instr;
            cycles = 0;
            @(posedge clk);
            // accepted on the first edge that sees in_ready_o high
            while (!in_ready_o) begin
                cycles++;
                assert (cycles < TIMEOUT_CYCLES)
                else stop_on_error("timeout waiting for in_ready_o");
                @(posedge clk);
            end
        end
        in_valid_i <= 1'b0;
    endtask

    task automatic collect_results();
        int idx;
        int idle;
        int edge_cnt;
        int last_edge;
        idx       = 0;
        idle      = 0;
        edge_cnt  = 0;
        last_edge = 0;
        wait_reset_release();
        while (idx < n_rows) begin
            @(posedge clk);
            edge_cnt++;
            if (!in_ready_o) begin
                ready_fell = 1'b1;
            end else if (ready_fell) begin
                ready_recovered = 1'b1;
            end
            if (out_valid_o && out_ready_i) begin
                // steady flow with out_ready_i high has no bubbles
                if (idx >= BACKPRESSURE_ROWS + 2) begin
                    assert (edge_cnt == last_edge + 1)
                    else stop_on_error("gap in the output stream with out_ready_i held high");
                end
                check_result(idx);
                last_edge = edge_cnt;
                idx++;
                idle = 0;
            end else begin
                idle++;
                assert (idle < TIMEOUT_CYCLES)
                else stop_on_error("timeout waiting for a result on out_valid_o");
            end
            if (idx < BACKPRESSURE_ROWS) begin
                out_ready_i <= ((lcg_next() >> 16) % 100) >= READY_LOW_PCT;
            end else begin
                out_ready_i <= 1'b1;
            end
        end
    endtask

    initial begin
        in_valid_i      = 1'b0;
        in_instr_i      = '0;
        out_ready_i     = 1'b0;
        ready_fell      = 1'b0;
        ready_recovered = 1'b0;
        n_rows          = 0;
        lcg_state       = 32'h4adf6091;
        build_table();
        fork
            drive_rows();
            collect_results();
        join
        // nothing may follow the last row
        repeat (10) begin
            @(posedge clk);
            assert (!out_valid_o)
            else stop_on_error("unexpected result after the last table row");
        end
        assert (ready_fell && ready_recovered)
        else stop_on_error("in_ready_o did not fall and recover under back-pressure");
        if (DUT.u_chk.error_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d bound assertion failures", DUT.u_chk.error_count);
            $display("Test FAILED");
            $fatal(1);
        end
    end

endmodule

// File: build.f
hw/core_pkg.sv
hw/decoder_i26.sv
hw/decoder_i16.sv
hw/fetch_producer.sv
hw/fetch_queue.sv
hw/branch_decode_stage.sv
hw/branch_decode_top.sv
bench/tb_clock_gen.sv
bench/branch_decode_chk.sv
bench/branch_decode_tb.sv
